// File: include/rvx_defines.svh
`ifndef RVX_DEFINES_SVH
`define RVX_DEFINES_SVH

// Data path width of the integer cluster
`define RVX_XLEN 32

// Register address width, 32 architectural registers
`define RVX_REG_AW 5

// Number of parallel execute lanes behind the dispatcher
`define RVX_NUM_LANES 3

`endif

// File: hw/rvx_isa_pkg.sv
`include "rvx_defines.svh"

package rvx_isa_pkg;

  // ##############################
  // Major opcodes
  // ##############################

  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111
  } opcode_e;

  // Function codes that need special handling in decode
  localparam logic [2:0] F3_SLL = 3'b001;
  localparam logic [2:0] F3_SRX = 3'b101;

  // Upper seven bits that select SUB and SRA
  localparam logic [6:0] F7_ALT = 7'b0100000;

  // ##############################
  // Instruction formats
  // ##############################

  typedef struct packed {
    logic [6:0]             funct7;
    logic [`RVX_REG_AW-1:0] rs2;
    logic [`RVX_REG_AW-1:0] rs1;
    logic [2:0]             funct3;
    logic [`RVX_REG_AW-1:0] rd;
    opcode_e                opcode;
  } r_view_t;

  typedef struct packed {
    logic [11:0]            imm;
    logic [`RVX_REG_AW-1:0] rs1;
    logic [2:0]             funct3;
    logic [`RVX_REG_AW-1:0] rd;
    opcode_e                opcode;
  } i_view_t;

  typedef struct packed {
    logic [19:0]            imm;
    logic [`RVX_REG_AW-1:0] rd;
    opcode_e                opcode;
  } u_view_t;

  // One instruction word seen through each encoding format
  typedef union packed {
    r_view_t r_view;
    i_view_t i_view;
    u_view_t u_view;
  } instr_u;

endpackage

// File: hw/rvx_exec_pkg.sv
package rvx_exec_pkg;

  // ALU operations, encoded exactly like funct3
  typedef enum logic [2:0] {
    ART_ADD  = 3'b000,
    ART_SLL  = 3'b001,
    ART_SLT  = 3'b010,
    ART_SLTU = 3'b011,
    ART_XOR  = 3'b100,
    ART_SR   = 3'b101,
    ART_OR   = 3'b110,
    ART_AND  = 3'b111
  } artop_e;

  // ##############################
  // Operand selection codes
  // ##############################

  // Operand A sources, in falling priority PC, zero, rs1
  localparam logic [1:0] OPA_RS1  = 2'd0;
  localparam logic [1:0] OPA_ZERO = 2'd1;
  localparam logic [1:0] OPA_PC   = 2'd2;

  // Operand B sources
  localparam logic OPB_RS2 = 1'b0;
  localparam logic OPB_IMM = 1'b1;

endpackage

// File: hw/alu.sv
`include "rvx_defines.svh"

module alu (
  input  rvx_exec_pkg::artop_e op_i,
  input  logic                 alt_i,
  input  logic [`RVX_XLEN-1:0] a_i,
  input  logic [`RVX_XLEN-1:0] b_i,
  output logic [`RVX_XLEN-1:0] o_o
);

  logic [4:0] shamt;

  // Only the low five bits count as shift amount
  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      rvx_exec_pkg::ART_ADD: begin
        if (alt_i) begin
          o_o = a_i - b_i;
        end else begin
          o_o = a_i + b_i;
        end
      end
      rvx_exec_pkg::ART_SLL: begin
        o_o = a_i << shamt;
      end
      rvx_exec_pkg::ART_SLT: begin
        o_o = {{(`RVX_XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
      end
      rvx_exec_pkg::ART_SLTU: begin
        o_o = {{(`RVX_XLEN-1){1'b0}}, a_i < b_i};
      end
      rvx_exec_pkg::ART_XOR: begin
        o_o = a_i ^ b_i;
      end
      rvx_exec_pkg::ART_SR: begin
        // Arithmetic shift keeps the sign bit
        if (alt_i) begin
          o_o = $unsigned($signed(a_i) >>> shamt);
        end else begin
          o_o = a_i >> shamt;
        end
      end
      rvx_exec_pkg::ART_OR: begin
        o_o = a_i | b_i;
      end
      rvx_exec_pkg::ART_AND: begin
        o_o = a_i & b_i;
      end
      default: begin
        o_o = '0;
      end
    endcase
  end

endmodule

// File: hw/execute_lane.sv
`include "rvx_defines.svh"

module execute_lane (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   issue_v_i,
  input  logic [`RVX_XLEN-1:0]   pc_i,
  input  logic [`RVX_XLEN-1:0]   rs1_data_i,
  input  logic [`RVX_XLEN-1:0]   rs2_data_i,
  input  logic [`RVX_XLEN-1:0]   imm_i,
  input  logic                   imm_v_i,
  input  logic                   imm_pass_v_i,
  input  logic                   pc_sel_i,
  input  rvx_exec_pkg::artop_e   artop_i,
  input  logic                   alt_i,
  input  logic [`RVX_REG_AW-1:0] rd_i,
  input  logic                   rd_w_v_i,
  input  logic                   take_i,
  output logic                   busy_o,
  output logic                   done_v_o,
  output logic [`RVX_REG_AW-1:0] rd_o,
  output logic                   rd_w_v_o,
  output logic [`RVX_XLEN-1:0]   result_o,
  output logic [`RVX_XLEN-1:0]   pc_o
);

  logic [1:0]           opa_sel;
  logic                 opb_sel;
  logic [`RVX_XLEN-1:0] src_a;
  logic [`RVX_XLEN-1:0] src_b;
  logic [`RVX_XLEN-1:0] alu_res;

  always_comb begin
    opa_sel = pc_sel_i ? rvx_exec_pkg::OPA_PC :
              (imm_pass_v_i ? rvx_exec_pkg::OPA_ZERO : rvx_exec_pkg::OPA_RS1);
    opb_sel = imm_v_i ? rvx_exec_pkg::OPB_IMM : rvx_exec_pkg::OPB_RS2;

    case (opa_sel)
      rvx_exec_pkg::OPA_PC:   src_a = pc_i;
      rvx_exec_pkg::OPA_ZERO: src_a = '0;
      default:                src_a = rs1_data_i;
    endcase

    src_b = (opb_sel == rvx_exec_pkg::OPB_IMM) ? imm_i : rs2_data_i;
  end

  alu u_alu (
    .op_i  (artop_i),
    .alt_i (alt_i),
    .a_i   (src_a),
    .b_i   (src_b),
    .o_o   (alu_res)
  );

  // Result stays valid until the collector takes it
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      done_v_o <= 1'b0;
    end else if (issue_v_i) begin
      done_v_o <= 1'b1;
    end else if (take_i) begin
      done_v_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_v_i) begin
      result_o <= alu_res;
      rd_o     <= rd_i;
      rd_w_v_o <= rd_w_v_i;
      pc_o     <= pc_i;
    end
  end

  assign busy_o = done_v_o | issue_v_i;

  // The dispatcher must only issue into an empty lane
  assert property (@(posedge clk) disable iff (!rst_n_i) issue_v_i |-> !done_v_o);

endmodule

// File: hw/issue_dispatch.sv
`include "rvx_defines.svh"

module issue_dispatch #(
  parameter int NUM_LANES = `RVX_NUM_LANES
) (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   instr_req_i,
  input  rvx_isa_pkg::instr_u    instr_i,
  input  logic [NUM_LANES-1:0]   lane_busy_i,
  input  logic                   wb_v_i,
  input  logic [`RVX_REG_AW-1:0] wb_rd_i,
  input  logic [`RVX_XLEN-1:0]   wb_data_i,
  output logic                   instr_ack_o,
  output logic [NUM_LANES-1:0]   issue_v_o,
  output logic [`RVX_XLEN-1:0]   pc_o,
  output logic [`RVX_XLEN-1:0]   rs1_data_o,
  output logic [`RVX_XLEN-1:0]   rs2_data_o,
  output logic [`RVX_XLEN-1:0]   imm_o,
  output logic                   imm_v_o,
  output logic                   imm_pass_v_o,
  output logic                   pc_sel_o,
  output rvx_exec_pkg::artop_e   artop_o,
  output logic                   alt_o,
  output logic [`RVX_REG_AW-1:0] rd_o,
  output logic                   rd_w_v_o
);

  localparam int PTR_W    = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
  localparam int NUM_REGS = 1 << `RVX_REG_AW;

  logic [`RVX_XLEN-1:0]   rf_q [NUM_REGS];
  logic [NUM_REGS-1:0]    sb_q;
  logic [NUM_REGS-1:0]    sb_next;
  logic [`RVX_XLEN-1:0]   pc_q;
  logic [PTR_W-1:0]       ptr_q;

  rvx_isa_pkg::opcode_e   opcode;
  logic [`RVX_REG_AW-1:0] rs1;
  logic [`RVX_REG_AW-1:0] rs2;
  logic [`RVX_REG_AW-1:0] rd;
  logic [`RVX_XLEN-1:0]   dec_imm;
  logic                   dec_imm_v;
  logic                   dec_pass;
  logic                   dec_pc_sel;
  logic                   dec_alt;
  logic                   dec_rd_w_v;
  rvx_exec_pkg::artop_e   dec_artop;
  logic                   use_rs1;
  logic                   use_rs2;
  logic                   hazard;
  logic                   fire;

  // A register is pending unless its writeback lands this cycle
  function automatic logic pending(input logic [`RVX_REG_AW-1:0] r);
    return sb_q[r] && !(wb_v_i && (wb_rd_i == r));
  endfunction

  function automatic logic [`RVX_XLEN-1:0] rf_read(input logic [`RVX_REG_AW-1:0] r);
    return (wb_v_i && (wb_rd_i == r)) ? wb_data_i : rf_q[r];
  endfunction

  // ##############################
  // Decode
  // ##############################

  assign opcode = instr_i.r_view.opcode;
  assign rs1    = instr_i.r_view.rs1;
  assign rs2    = instr_i.r_view.rs2;
  assign rd     = instr_i.r_view.rd;

  always_comb begin
    dec_imm    = '0;
    dec_imm_v  = 1'b0;
    dec_pass   = 1'b0;
    dec_pc_sel = 1'b0;
    dec_alt    = 1'b0;
    dec_rd_w_v = 1'b0;
    dec_artop  = rvx_exec_pkg::ART_ADD;
    use_rs1    = 1'b0;
    use_rs2    = 1'b0;
    case (opcode)
      rvx_isa_pkg::OP: begin
        dec_artop  = rvx_exec_pkg::artop_e'(instr_i.r_view.funct3);
        dec_alt    = instr_i.r_view.funct7 == rvx_isa_pkg::F7_ALT;
        dec_rd_w_v = 1'b1;
        use_rs1    = 1'b1;
        use_rs2    = 1'b1;
      end
      rvx_isa_pkg::OP_IMM: begin
        dec_imm    = {{(`RVX_XLEN-12){instr_i.i_view.imm[11]}}, instr_i.i_view.imm};
        dec_imm_v  = 1'b1;
        dec_artop  = rvx_exec_pkg::artop_e'(instr_i.i_view.funct3);
        // Upper immediate bits select SRAI, for other operations they are data
        dec_alt    = (instr_i.i_view.funct3 == rvx_isa_pkg::F3_SLL ||
                      instr_i.i_view.funct3 == rvx_isa_pkg::F3_SRX) &&
                     (instr_i.i_view.imm[11:5] == rvx_isa_pkg::F7_ALT);
        dec_rd_w_v = 1'b1;
        use_rs1    = 1'b1;
      end
      rvx_isa_pkg::LUI, rvx_isa_pkg::AUIPC: begin
        dec_imm    = {instr_i.u_view.imm, 12'b0};
        dec_imm_v  = 1'b1;
        dec_pass   = opcode == rvx_isa_pkg::LUI;
        dec_pc_sel = opcode == rvx_isa_pkg::AUIPC;
        dec_rd_w_v = 1'b1;
      end
      default: begin
        dec_rd_w_v = 1'b0;
      end
    endcase
  end

  // ##############################
  // Hazards and issue
  // ##############################

  // The rd check keeps an older writeback from clearing a newer claim
  assign hazard = (use_rs1 && pending(rs1)) || (use_rs2 && pending(rs2)) || pending(rd);
  assign fire   = instr_req_i && !instr_ack_o && !lane_busy_i[ptr_q] && !hazard;

  always_comb begin
    sb_next = sb_q;
    if (wb_v_i) begin
      sb_next[wb_rd_i] = 1'b0;
    end
    if (fire && dec_rd_w_v && (rd != '0)) begin
      sb_next[rd] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      instr_ack_o <= 1'b0;
      issue_v_o   <= '0;
      pc_q        <= '0;
      ptr_q       <= '0;
      sb_q        <= '0;
      for (int i = 0; i < NUM_REGS; i++) begin
        rf_q[i] <= '0;
      end
    end else begin
      issue_v_o <= '0;
      sb_q      <= sb_next;
      if (wb_v_i) begin
        rf_q[wb_rd_i] <= wb_data_i;
      end
      if (fire) begin
        instr_ack_o      <= 1'b1;
        issue_v_o[ptr_q] <= 1'b1;
        pc_q             <= pc_q + `RVX_XLEN'd4;
        ptr_q            <= (ptr_q == PTR_W'(NUM_LANES - 1)) ? '0 : ptr_q + 1'b1;
      end else if (!instr_req_i) begin
        instr_ack_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      pc_o         <= pc_q;
      rs1_data_o   <= rf_read(rs1);
      rs2_data_o   <= rf_read(rs2);
      imm_o        <= dec_imm;
      imm_v_o      <= dec_imm_v;
      imm_pass_v_o <= dec_pass;
      pc_sel_o     <= dec_pc_sel;
      artop_o      <= dec_artop;
      alt_o        <= dec_alt;
      rd_o         <= rd;
      rd_w_v_o     <= dec_rd_w_v;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n_i)
    fire |-> opcode inside {rvx_isa_pkg::OP, rvx_isa_pkg::OP_IMM,
                            rvx_isa_pkg::LUI, rvx_isa_pkg::AUIPC});

endmodule

// File: hw/retire_collector.sv
`include "rvx_defines.svh"

module retire_collector #(
  parameter int NUM_LANES = `RVX_NUM_LANES
) (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic [NUM_LANES-1:0]   done_v_i,
  input  logic [`RVX_REG_AW-1:0] lane_rd_i     [NUM_LANES],
  input  logic                   lane_rd_w_v_i [NUM_LANES],
  input  logic [`RVX_XLEN-1:0]   lane_result_i [NUM_LANES],
  input  logic [`RVX_XLEN-1:0]   lane_pc_i     [NUM_LANES],
  input  logic                   res_ack_i,
  output logic [NUM_LANES-1:0]   take_o,
  output logic                   wb_v_o,
  output logic [`RVX_REG_AW-1:0] wb_rd_o,
  output logic [`RVX_XLEN-1:0]   wb_data_o,
  output logic                   res_req_o,
  output logic [`RVX_REG_AW-1:0] res_rd_o,
  output logic [`RVX_XLEN-1:0]   res_data_o,
  output logic [`RVX_XLEN-1:0]   res_pc_o
);

  localparam int PTR_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  logic [PTR_W-1:0] ptr_q;
  logic             ack_wait_q;
  logic             take_now;

  // Take only while no output handshake is in progress
  assign take_now = !res_req_o && !ack_wait_q && done_v_i[ptr_q];

  always_comb begin
    take_o        = '0;
    take_o[ptr_q] = take_now;
  end

  assign wb_v_o    = take_now && lane_rd_w_v_i[ptr_q] && (lane_rd_i[ptr_q] != '0);
  assign wb_rd_o   = lane_rd_i[ptr_q];
  assign wb_data_o = lane_result_i[ptr_q];

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      res_req_o  <= 1'b0;
      ack_wait_q <= 1'b0;
      ptr_q      <= '0;
    end else if (take_now) begin
      res_req_o <= 1'b1;
    end else if (res_req_o && res_ack_i) begin
      res_req_o  <= 1'b0;
      ack_wait_q <= 1'b1;
    end else if (ack_wait_q && !res_ack_i) begin
      ack_wait_q <= 1'b0;
      ptr_q      <= (ptr_q == PTR_W'(NUM_LANES - 1)) ? '0 : ptr_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (take_now) begin
      res_rd_o   <= lane_rd_i[ptr_q];
      res_data_o <= lane_result_i[ptr_q];
      res_pc_o   <= lane_pc_i[ptr_q];
    end
  end

  // The host keeps ack high until it has seen req fall
  assert property (@(posedge clk) disable iff (!rst_n_i) res_req_o && res_ack_i |=> res_ack_i);

endmodule

// File: hw/rvx_exec_cluster.sv
`include "rvx_defines.svh"

module rvx_exec_cluster (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   instr_req_i,
  input  rvx_isa_pkg::instr_u    instr_i,
  input  logic                   res_ack_i,
  output logic                   instr_ack_o,
  output logic                   res_req_o,
  output logic [`RVX_REG_AW-1:0] res_rd_o,
  output logic [`RVX_XLEN-1:0]   res_data_o,
  output logic [`RVX_XLEN-1:0]   res_pc_o
);

  localparam int NL = `RVX_NUM_LANES;

  // ##############################
  // Issue side
  // ##############################

  logic [NL-1:0]          issue_v;
  logic [NL-1:0]          lane_busy;
  logic [`RVX_XLEN-1:0]   is_pc;
  logic [`RVX_XLEN-1:0]   is_rs1_data;
  logic [`RVX_XLEN-1:0]   is_rs2_data;
  logic [`RVX_XLEN-1:0]   is_imm;
  logic                   is_imm_v;
  logic                   is_pass;
  logic                   is_pc_sel;
  rvx_exec_pkg::artop_e   is_artop;
  logic                   is_alt;
  logic [`RVX_REG_AW-1:0] is_rd;
  logic                   is_rd_w_v;

  // Retire side
  logic [NL-1:0]          done_v;
  logic [NL-1:0]          take;
  logic [`RVX_REG_AW-1:0] lane_rd     [NL];
  logic                   lane_rd_w_v [NL];
  logic [`RVX_XLEN-1:0]   lane_result [NL];
  logic [`RVX_XLEN-1:0]   lane_pc     [NL];
  logic                   wb_v;
  logic [`RVX_REG_AW-1:0] wb_rd;
  logic [`RVX_XLEN-1:0]   wb_data;

  issue_dispatch #(.NUM_LANES(NL)) u_dispatch (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .instr_req_i  (instr_req_i),
    .instr_i      (instr_i),
    .lane_busy_i  (lane_busy),
    .wb_v_i       (wb_v),
    .wb_rd_i      (wb_rd),
    .wb_data_i    (wb_data),
    .instr_ack_o  (instr_ack_o),
    .issue_v_o    (issue_v),
    .pc_o         (is_pc),
    .rs1_data_o   (is_rs1_data),
    .rs2_data_o   (is_rs2_data),
    .imm_o        (is_imm),
    .imm_v_o      (is_imm_v),
    .imm_pass_v_o (is_pass),
    .pc_sel_o     (is_pc_sel),
    .artop_o      (is_artop),
    .alt_o        (is_alt),
    .rd_o         (is_rd),
    .rd_w_v_o     (is_rd_w_v)
  );

  // All lanes share the issue payload, issue_v picks one
  for (genvar k = 0; k < NL; k++) begin : g_lane
    execute_lane u_lane (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .issue_v_i    (issue_v[k]),
      .pc_i         (is_pc),
      .rs1_data_i   (is_rs1_data),
      .rs2_data_i   (is_rs2_data),
      .imm_i        (is_imm),
      .imm_v_i      (is_imm_v),
      .imm_pass_v_i (is_pass),
      .pc_sel_i     (is_pc_sel),
      .artop_i      (is_artop),
      .alt_i        (is_alt),
      .rd_i         (is_rd),
      .rd_w_v_i     (is_rd_w_v),
      .take_i       (take[k]),
      .busy_o       (lane_busy[k]),
      .done_v_o     (done_v[k]),
      .rd_o         (lane_rd[k]),
      .rd_w_v_o     (lane_rd_w_v[k]),
      .result_o     (lane_result[k]),
      .pc_o         (lane_pc[k])
    );
  end

  retire_collector #(.NUM_LANES(NL)) u_collector (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .done_v_i      (done_v),
    .lane_rd_i     (lane_rd),
    .lane_rd_w_v_i (lane_rd_w_v),
    .lane_result_i (lane_result),
    .lane_pc_i     (lane_pc),
    .res_ack_i     (res_ack_i),
    .take_o        (take),
    .wb_v_o        (wb_v),
    .wb_rd_o       (wb_rd),
    .wb_data_o     (wb_data),
    .res_req_o     (res_req_o),
    .res_rd_o      (res_rd_o),
    .res_data_o    (res_data_o),
    .res_pc_o      (res_pc_o)
  );

endmodule

// File: tests/rvx_cluster_tb.sv
`include "rvx_defines.svh"

module rvx_cluster_tb;

  localparam int RANDOM_LEN  = 64;
  localparam int CYC_PER_INS = 200;

  // RV32I funct3 values
  localparam logic [2:0] F_ADD  = 3'd0;
  localparam logic [2:0] F_SLL  = 3'd1;
  localparam logic [2:0] F_SLT  = 3'd2;
  localparam logic [2:0] F_SLTU = 3'd3;
  localparam logic [2:0] F_XOR  = 3'd4;
  localparam logic [2:0] F_SR   = 3'd5;
  localparam logic [2:0] F_OR   = 3'd6;
  localparam logic [2:0] F_AND  = 3'd7;

  logic                   clk;
  logic                   rst_n_i;
  logic                   instr_req_i;
  logic [31:0]            instr_i;
  logic                   res_ack_i;
  logic                   instr_ack_o;
  logic                   res_req_o;
  logic [`RVX_REG_AW-1:0] res_rd_o;
  logic [`RVX_XLEN-1:0]   res_data_o;
  logic [`RVX_XLEN-1:0]   res_pc_o;

  // Architectural state as the host expects it after each sent instruction
  logic [`RVX_XLEN-1:0]   model_rf [32];
  logic [`RVX_XLEN-1:0]   model_pc;
  logic [`RVX_REG_AW-1:0] exp_rd [$];
  logic [`RVX_XLEN-1:0]   exp_data [$];
  logic [`RVX_XLEN-1:0]   exp_pc [$];
  int                     sent_cnt;
  logic [15:0]            stim_lfsr;
  logic [15:0]            ack_lfsr;

  rvx_exec_cluster DUT (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .instr_req_i (instr_req_i),
    .instr_i     (instr_i),
    .res_ack_i   (res_ack_i),
    .instr_ack_o (instr_ack_o),
    .res_req_o   (res_req_o),
    .res_rd_o    (res_rd_o),
    .res_data_o  (res_data_o),
    .res_pc_o    (res_pc_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ##############################
  // Helpers
  // ##############################

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(inout logic [15:0] st, input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      st = lfsr_step(st);
      v  = {v[30:0], st[0]};
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at %0t: %s is 0x%08h, expected 0x%08h", $time, name, got, exp));
    end
  endtask

  // RV32I semantics, shifts use the low five bits of b
  function automatic logic [31:0] ref_op(input logic [2:0] f3, input logic alt,
                                         input logic [31:0] a, input logic [31:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (f3)
      F_ADD:   return alt ? a - b : a + b;
      F_SLL:   return a << sh;
      F_SLT:   return {31'b0, (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)};
      F_SLTU:  return {31'b0, a < b};
      F_XOR:   return a ^ b;
      F_SR:    return (a >> sh) | ((alt && a[31]) ? ~(32'hffff_ffff >> sh) : 32'h0);
      F_OR:    return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic send_instr(input logic [31:0] word);
    @(posedge clk);
    instr_i     <= word;
    instr_req_i <= 1'b1;
    sent_cnt++;
    do begin
      @(posedge clk);
    end while (!instr_ack_o);
    instr_req_i <= 1'b0;
    do begin
      @(posedge clk);
    end while (instr_ack_o);
  endtask

  task automatic expect_result(input logic [4:0] rd, input logic [31:0] value);
    exp_rd.push_back(rd);
    exp_data.push_back(value);
    exp_pc.push_back(model_pc);
    if (rd != 5'd0) begin
      model_rf[rd] = value;
    end
    model_pc = model_pc + 32'd4;
  endtask

  task automatic do_r(input logic [2:0] f3, input logic alt, input logic [4:0] rd,
                      input logic [4:0] rs1, input logic [4:0] rs2);
    expect_result(rd, ref_op(f3, alt, model_rf[rs1], model_rf[rs2]));
    send_instr({alt ? 7'b0100000 : 7'b0, rs2, rs1, f3, rd, rvx_isa_pkg::OP});
  endtask

  task automatic do_i(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                      input logic [11:0] imm);
    logic alt;
    alt = (f3 == F_SR) && (imm[11:5] == 7'b0100000);
    expect_result(rd, ref_op(f3, alt, model_rf[rs1], {{20{imm[11]}}, imm}));
    send_instr({imm, rs1, f3, rd, rvx_isa_pkg::OP_IMM});
  endtask

  task automatic do_u(input logic pc_rel, input logic [4:0] rd, input logic [19:0] imm);
    expect_result(rd, (pc_rel ? model_pc : 32'h0) + {imm, 12'b0});
    send_instr({imm, rd, pc_rel ? rvx_isa_pkg::AUIPC : rvx_isa_pkg::LUI});
  endtask

  // Completes each output handshake after 0 to 3 cycles
  task automatic receive_results();
    logic [31:0] delay;
    forever begin
      @(posedge clk);
      if (res_req_o) begin
        if (exp_data.size() == 0) begin
          abort_run("DUT reported a result with no instruction outstanding");
        end else begin
          check_eq("res_rd_o", 32'(res_rd_o), 32'(exp_rd.pop_front()));
          check_eq("res_data_o", res_data_o, exp_data.pop_front());
          check_eq("res_pc_o", res_pc_o, exp_pc.pop_front());
        end
        draw_bits(ack_lfsr, 2, delay);
        repeat (delay) @(posedge clk);
        res_ack_i <= 1'b1;
        do begin
          @(posedge clk);
        end while (res_req_o);
        res_ack_i <= 1'b0;
      end
    end
  endtask

  // ##############################
  // Directed tests
  // ##############################

  task automatic test_r_ops();
    do_i(F_ADD, 5'd1, 5'd0, 12'hff9);
    do_i(F_ADD, 5'd2, 5'd0, 12'h003);
    do_i(F_ADD, 5'd3, 5'd0, 12'h5a5);
    do_r(F_ADD, 1'b0, 5'd4, 5'd1, 5'd2);
    do_r(F_ADD, 1'b1, 5'd5, 5'd2, 5'd1);
    do_r(F_SLL, 1'b0, 5'd6, 5'd3, 5'd2);
    do_r(F_SLT, 1'b0, 5'd7, 5'd1, 5'd2);
    do_r(F_SLTU, 1'b0, 5'd8, 5'd1, 5'd2);
    do_r(F_XOR, 1'b0, 5'd9, 5'd1, 5'd3);
    do_r(F_SR, 1'b0, 5'd10, 5'd1, 5'd2);
    do_r(F_SR, 1'b1, 5'd11, 5'd1, 5'd2);
    do_r(F_OR, 1'b0, 5'd12, 5'd1, 5'd3);
    do_r(F_AND, 1'b0, 5'd12, 5'd1, 5'd3);
  endtask

  task automatic test_immediates();
    do_i(F_ADD, 5'd13, 5'd0, 12'h800);
    do_i(F_SLT, 5'd14, 5'd1, 12'hfff);
    do_i(F_SLTU, 5'd15, 5'd2, 12'hfff);
    do_i(F_XOR, 5'd16, 5'd1, 12'h7ff);
    do_i(F_OR, 5'd17, 5'd3, 12'h80a);
    do_i(F_AND, 5'd18, 5'd1, 12'hf0f);
    do_i(F_SLL, 5'd19, 5'd3, 12'h004);
    do_i(F_SR, 5'd20, 5'd1, 12'h01c);
    do_i(F_SR, 5'd21, 5'd1, 12'h402);
    do_i(F_SR, 5'd21, 5'd13, 12'h41f);
    do_u(1'b0, 5'd22, 20'habcde);
    do_u(1'b1, 5'd23, 20'h00001);
  endtask

  // Every instruction reads the rd of the one before
  task automatic test_dependency();
    do_i(F_ADD, 5'd24, 5'd0, 12'h005);
    do_r(F_ADD, 1'b0, 5'd24, 5'd24, 5'd24);
    do_r(F_ADD, 1'b0, 5'd24, 5'd24, 5'd24);
    do_r(F_ADD, 1'b1, 5'd25, 5'd24, 5'd1);
    do_i(F_XOR, 5'd25, 5'd25, 12'h0f0);
    do_i(F_SLL, 5'd26, 5'd25, 12'h003);
    do_r(F_OR, 1'b0, 5'd27, 5'd26, 5'd25);
  endtask

  task automatic test_x0();
    do_i(F_ADD, 5'd0, 5'd1, 12'h064);
    do_r(F_ADD, 1'b0, 5'd28, 5'd0, 5'd2);
    do_u(1'b0, 5'd0, 20'h12345);
    do_i(F_ADD, 5'd29, 5'd0, 12'h000);
  endtask

  task automatic test_random();
    logic [31:0] kind;
    logic [31:0] f3;
    logic [31:0] rd;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [31:0] alt;
    logic [31:0] imm;
    for (int n = 0; n < RANDOM_LEN; n++) begin
      draw_bits(stim_lfsr, 2, kind);
      draw_bits(stim_lfsr, 3, f3);
      draw_bits(stim_lfsr, 5, rd);
      draw_bits(stim_lfsr, 5, rs1);
      draw_bits(stim_lfsr, 5, rs2);
      draw_bits(stim_lfsr, 1, alt);
      case (kind[1:0])
        2'd0, 2'd1: begin
          if (f3[2:0] != F_ADD && f3[2:0] != F_SR) begin
            alt = '0;
          end
          do_r(f3[2:0], alt[0], rd[4:0], rs1[4:0], rs2[4:0]);
        end
        2'd2: begin
          if (f3[2:0] == F_SLL || f3[2:0] == F_SR) begin
            imm = {20'b0, (alt[0] && f3[2:0] == F_SR) ? 7'b0100000 : 7'b0, rs2[4:0]};
          end else begin
            draw_bits(stim_lfsr, 12, imm);
          end
          do_i(f3[2:0], rd[4:0], rs1[4:0], imm[11:0]);
        end
        default: begin
          draw_bits(stim_lfsr, 20, imm);
          do_u(alt[0], rd[4:0], imm[19:0]);
        end
      endcase
    end
  endtask

  // ##############################
  // Run control
  // ##############################

  initial begin
    int cycles;
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > CYC_PER_INS * (sent_cnt + 1)) begin
        abort_run($sformatf("Timeout after %0d cycles with %0d instructions sent",
                            cycles, sent_cnt));
      end
    end
  end

  initial begin
    rst_n_i     = 1'b0;
    instr_req_i = 1'b0;
    instr_i     = '0;
    res_ack_i   = 1'b0;
    sent_cnt    = 0;
    model_pc    = '0;
    stim_lfsr   = 16'd41146;
    ack_lfsr    = 16'd41146;
    for (int i = 0; i < 32; i++) begin
      model_rf[i] = '0;
    end
    repeat (4) @(posedge clk);
    rst_n_i <= 1'b1;
    fork
      receive_results();
    join_none
    test_r_ops();
    test_immediates();
    test_dependency();
    test_x0();
    test_random();
    while (exp_data.size() != 0) begin
      @(posedge clk);
    end
    // Leave room for a duplicate result to show up
    repeat (20) @(posedge clk);
    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: src.f
+incdir+include
hw/rvx_isa_pkg.sv
hw/rvx_exec_pkg.sv
hw/alu.sv
hw/execute_lane.sv
hw/issue_dispatch.sv
hw/retire_collector.sv
hw/rvx_exec_cluster.sv
tests/rvx_cluster_tb.sv

// File: run.sh
#!/bin/sh
# Builds the cluster testbench with Verilator and runs it.
# A failing check ends the simulation with $fatal, so the exit status carries the result.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -j 0 \
  --top-module rvx_cluster_tb \
  -f src.f \
  -o rvx_cluster_sim

./obj_dir/rvx_cluster_sim
